//--- src/core_pkg.sv
// Core pipeline shared types
`default_nettype none

package core_pkg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Instruction encodings
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	typedef enum logic [5:0] {
		op_rtype = 6'h00, // Function code selects the operation.
		op_addiu = 6'h09,
		op_slti  = 6'h0a,
		op_andi  = 6'h0c,
		op_ori   = 6'h0d,
		op_xori  = 6'h0e,
		op_lui   = 6'h0f,
		op_lw    = 6'h23,
		op_sw    = 6'h2b
	} op_t;

	typedef enum logic [5:0] {
		fn_sll  = 6'h00,
		fn_srl  = 6'h02,
		fn_addu = 6'h21,
		fn_subu = 6'h23,
		fn_and  = 6'h24,
		fn_or   = 6'h25,
		fn_xor  = 6'h26,
		fn_slt  = 6'h2a
	} funct_t;

	typedef enum logic [3:0] {
		alu_add, alu_sub, alu_and, alu_or, alu_xor,
		alu_slt, alu_sll, alu_srl, alu_lui,
		alu_pass // Result is zero, used by illegal instructions.
	} alu_op_t;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Stage payloads
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	typedef struct packed {
		logic [31:0] pc;
		logic [31:0] inst;
	} fetch_t;

	typedef struct packed {
		logic [31:0] pc;
		logic [31:0] rs_val;
		logic [31:0] op2;     // The rt value or the extended immediate.
		logic [31:0] st_data; // The rt value, needed by sw next to its offset.
		logic [4:0]  shamt;
		alu_op_t     alu_op;
		logic [4:0]  waddr;
		logic        rfw;
		logic        mem_read;
		logic        mem_write;
		logic        illegal;
	} decode_t;

	typedef struct packed {
		logic [31:0] pc;
		logic [31:0] result; // ALU result or memory byte address.
		logic [31:0] st_data;
		logic [4:0]  waddr;
		logic        rfw;
		logic        mem_read;
		logic        mem_write;
		logic        illegal;
	} exec_t;

	typedef struct packed {
		logic [31:0] pc;
		logic        wen;
		logic [4:0]  waddr;
		logic [31:0] wdata;
		logic        illegal;
	} retire_t;

endpackage

`default_nettype wire

//--- src/inst_fetch.sv
// Instruction input stage
`timescale 1ns/10ps
`default_nettype none

module inst_fetch import core_pkg::*; (
	input  logic        clk,
	input  logic        rst,
	input  logic        inst_valid,
	output logic        inst_ready,
	input  logic [31:0] inst_data,
	output logic        f2d_valid,
	input  logic        f2d_ready,
	output fetch_t      f2d_data
);

	logic        run;  // Low in reset, so no word is taken before the core is up.
	logic [31:0] pc_q; // Program counter given to the next accepted word.
	logic        take;

	assign inst_ready = run && (!f2d_valid || f2d_ready);
	assign take = inst_valid && inst_ready;

	always_ff @(posedge clk) begin
		if (rst) begin
			run <= 1'b0;
			pc_q <= '0;
			f2d_valid <= 1'b0;
		end else begin
			run <= 1'b1;
			if (take) begin
				pc_q <= pc_q + 32'd4;
				f2d_valid <= 1'b1;
			end else if (f2d_ready) begin
				f2d_valid <= 1'b0;
			end
		end
	end

	// Payload register.
	always_ff @(posedge clk) begin
		if (take) begin
			f2d_data.pc <= pc_q;
			f2d_data.inst <= inst_data;
		end
	end

	// Decode may stall on a hazard for many cycles, the word must not move meanwhile.
	a_f2d_stable: assert property (@(posedge clk) disable iff (rst)
		f2d_valid && !f2d_ready |=> f2d_valid && $stable(f2d_data))
		else $error("f2d payload changed while waiting for decode");

endmodule

`default_nettype wire

//--- src/inst_decode.sv
// Instruction decode stage
`timescale 1ns/10ps
`default_nettype none

module inst_decode import core_pkg::*; (
	input  logic        clk,
	input  logic        rst,
	input  logic        f2d_valid,
	output logic        f2d_ready,
	input  fetch_t      f2d_data,
	output logic        d2e_valid,
	input  logic        d2e_ready,
	output decode_t     d2e_data,
	input  logic        wb_en,
	input  logic [4:0]  wb_addr,
	input  logic [31:0] wb_data
);

	logic [31:0] rf [1:31]; // r0 is not stored.
	logic [31:0] sb;        // One pending bit per register.

	op_t         op;
	funct_t      fn;
	logic [4:0]  rs, rt, rd, shamt;
	logic [15:0] imm;
	logic [31:0] rs_val, rt_val, imm_ext;

	alu_op_t    alu_op;
	logic       imm_sext, use_imm, use_rt, dest_rt;
	logic       rfw, mem_read, mem_write, illegal;
	logic [4:0] waddr;
	logic       hazard, issue;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Field split and operand read
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	assign op = op_t'(f2d_data.inst[31:26]);
	assign fn = funct_t'(f2d_data.inst[5:0]);
	assign rs = f2d_data.inst[25:21];
	assign rt = f2d_data.inst[20:16];
	assign rd = f2d_data.inst[15:11];
	assign shamt = f2d_data.inst[10:6];
	assign imm = f2d_data.inst[15:0];

	assign rs_val = (rs == 5'd0) ? '0 : rf[rs];
	assign rt_val = (rt == 5'd0) ? '0 : rf[rt];
	assign imm_ext = imm_sext ? {{16{imm[15]}}, imm} : {16'h0, imm};

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Control generation
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_comb begin
		alu_op = alu_pass;
		imm_sext = 1'b1;
		use_imm = 1'b1;
		use_rt = 1'b0;
		dest_rt = 1'b1;
		rfw = 1'b1;
		mem_read = 1'b0;
		mem_write = 1'b0;
		illegal = 1'b0;
		case (op)
			op_rtype: begin
				use_imm = 1'b0;
				use_rt = 1'b1;
				dest_rt = 1'b0;
				case (fn)
					fn_addu: alu_op = alu_add;
					fn_subu: alu_op = alu_sub;
					fn_and:  alu_op = alu_and;
					fn_or:   alu_op = alu_or;
					fn_xor:  alu_op = alu_xor;
					fn_slt:  alu_op = alu_slt;
					fn_sll:  alu_op = alu_sll;
					fn_srl:  alu_op = alu_srl;
					default: illegal = 1'b1;
				endcase
			end
			op_addiu: alu_op = alu_add;
			op_slti:  alu_op = alu_slt;
			op_andi: begin
				alu_op = alu_and;
				imm_sext = 1'b0;
			end
			op_ori: begin
				alu_op = alu_or;
				imm_sext = 1'b0;
			end
			op_xori: begin
				alu_op = alu_xor;
				imm_sext = 1'b0;
			end
			op_lui: begin
				alu_op = alu_lui;
				imm_sext = 1'b0;
			end
			op_lw: begin
				alu_op = alu_add; // Address is rs plus the offset.
				mem_read = 1'b1;
			end
			op_sw: begin
				alu_op = alu_add;
				use_rt = 1'b1;
				rfw = 1'b0;
				mem_write = 1'b1;
			end
			default: illegal = 1'b1;
		endcase
		if (illegal) begin
			alu_op = alu_pass;
			rfw = 1'b0;
		end
	end

	assign waddr = !rfw ? 5'd0 : (dest_rt ? rt : rd);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Scoreboard and issue
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// The destination is checked too, so an older write cannot clear a newer pending bit.
	assign hazard = sb[rs] || (use_rt && sb[rt]) || (rfw && sb[waddr]);
	assign f2d_ready = !hazard && (!d2e_valid || d2e_ready);
	assign issue = f2d_valid && f2d_ready;

	always_ff @(posedge clk) begin
		if (rst) begin
			sb <= '0;
			d2e_valid <= 1'b0;
		end else begin
			// Clear first, so a set on the same register wins. Bit 0 is never set.
			sb <= (sb & ~(wb_en ? (32'd1 << wb_addr) : 32'd0))
				| ((issue && waddr != 5'd0) ? (32'd1 << waddr) : 32'd0);
			if (issue)
				d2e_valid <= 1'b1;
			else if (d2e_ready)
				d2e_valid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (issue) begin
			d2e_data.pc <= f2d_data.pc;
			d2e_data.rs_val <= rs_val;
			d2e_data.op2 <= use_imm ? imm_ext : rt_val;
			d2e_data.st_data <= rt_val;
			d2e_data.shamt <= shamt;
			d2e_data.alu_op <= alu_op;
			d2e_data.waddr <= waddr;
			d2e_data.rfw <= rfw;
			d2e_data.mem_read <= mem_read;
			d2e_data.mem_write <= mem_write;
			d2e_data.illegal <= illegal;
		end
		if (wb_en && wb_addr != 5'd0)
			rf[wb_addr] <= wb_data; // Write-back from the retire port.
	end

	// A register still on its way back through write-back must keep its readers waiting.
	a_no_raw_issue: assert property (@(posedge clk) disable iff (rst)
		issue && wb_en && wb_addr != 5'd0 |-> wb_addr != rs && !(use_rt && wb_addr == rt))
		else $error("instruction issued while a source register was still pending");

endmodule

`default_nettype wire

//--- src/alu_execute.sv
// ALU execute stage
`timescale 1ns/10ps
`default_nettype none

module alu_execute import core_pkg::*; (
	input  logic    clk,
	input  logic    rst,
	input  logic    d2e_valid,
	output logic    d2e_ready,
	input  decode_t d2e_data,
	output logic    e2m_valid,
	input  logic    e2m_ready,
	output exec_t   e2m_data
);

	logic [31:0] a, b, result;
	logic        take;

	assign a = d2e_data.rs_val;
	assign b = d2e_data.op2;

	// Loads and stores arrive as alu_add, which forms rs plus the signed offset.
	always_comb begin
		case (d2e_data.alu_op)
			alu_add:  result = a + b;
			alu_sub:  result = a - b;
			alu_and:  result = a & b;
			alu_or:   result = a | b;
			alu_xor:  result = a ^ b;
			alu_slt:  result = {31'd0, $signed(a) < $signed(b)};
			alu_sll:  result = b << d2e_data.shamt;
			alu_srl:  result = b >> d2e_data.shamt;
			alu_lui:  result = {b[15:0], 16'h0000};
			alu_pass: result = '0;
			default:  result = '0;
		endcase
	end

	assign d2e_ready = !e2m_valid || e2m_ready;
	assign take = d2e_valid && d2e_ready;

	always_ff @(posedge clk) begin
		if (rst)
			e2m_valid <= 1'b0;
		else if (take)
			e2m_valid <= 1'b1;
		else if (e2m_ready)
			e2m_valid <= 1'b0;
	end

	always_ff @(posedge clk) begin
		if (take) begin
			e2m_data.pc <= d2e_data.pc;
			e2m_data.result <= result;
			e2m_data.st_data <= d2e_data.st_data; // Carried for sw.
			e2m_data.waddr <= d2e_data.waddr;
			e2m_data.rfw <= d2e_data.rfw;
			e2m_data.mem_read <= d2e_data.mem_read;
			e2m_data.mem_write <= d2e_data.mem_write;
			e2m_data.illegal <= d2e_data.illegal;
		end
	end

endmodule

`default_nettype wire

//--- src/data_mem_stage.sv
// Data memory stage
`timescale 1ns/10ps
`default_nettype none

module data_mem_stage import core_pkg::*; #(
	parameter int DMEM_WORDS = 64 // Must be a power of two.
) (
	input  logic    clk,
	input  logic    rst,
	input  logic    e2m_valid,
	output logic    e2m_ready,
	input  exec_t   e2m_data,
	output logic    m2r_valid,
	input  logic    m2r_ready,
	output retire_t m2r_data
);

	localparam int IDX_W = $clog2(DMEM_WORDS);

	logic [31:0]      mem [DMEM_WORDS];
	logic [IDX_W-1:0] idx;
	logic             take;

	// Word index, higher address bits alias onto the same entry.
	assign idx = e2m_data.result[IDX_W+1:2];

	assign e2m_ready = !m2r_valid || m2r_ready;
	assign take = e2m_valid && e2m_ready;

	always_ff @(posedge clk) begin
		if (rst)
			m2r_valid <= 1'b0;
		else if (take)
			m2r_valid <= 1'b1;
		else if (m2r_ready)
			m2r_valid <= 1'b0;
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Memory access and retire record
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge clk) begin
		if (take && e2m_data.mem_write)
			mem[idx] <= e2m_data.st_data;
		if (take) begin
			m2r_data.pc <= e2m_data.pc;
			m2r_data.wen <= e2m_data.rfw && !e2m_data.illegal;
			m2r_data.waddr <= e2m_data.waddr;
			m2r_data.wdata <= e2m_data.mem_read ? mem[idx] : e2m_data.result;
			m2r_data.illegal <= e2m_data.illegal;
		end
	end

	a_rw_exclusive: assert property (@(posedge clk) disable iff (rst)
		e2m_valid |-> !(e2m_data.mem_read && e2m_data.mem_write))
		else $error("memory read and write requested together");

endmodule

`default_nettype wire

//--- src/retire_port.sv
// Retire output stage
`timescale 1ns/10ps
`default_nettype none

module retire_port import core_pkg::*; (
	input  logic        clk,
	input  logic        rst,
	input  logic        m2r_valid,
	output logic        m2r_ready,
	input  retire_t     m2r_data,
	output logic        retire_valid,
	input  logic        retire_ready,
	output retire_t     retire_data,
	output logic        wb_en,
	output logic [4:0]  wb_addr,
	output logic [31:0] wb_data
);

	logic take;

	assign m2r_ready = !retire_valid || retire_ready;
	assign take = m2r_valid && m2r_ready;

	always_ff @(posedge clk) begin
		if (rst)
			retire_valid <= 1'b0;
		else if (take)
			retire_valid <= 1'b1;
		else if (retire_ready)
			retire_valid <= 1'b0;
	end

	always_ff @(posedge clk) begin
		if (take)
			retire_data <= m2r_data;
	end

	// The register file is written only when the record leaves the core.
	assign wb_en = retire_valid && retire_ready && retire_data.wen;
	assign wb_addr = retire_data.waddr;
	assign wb_data = retire_data.wdata;

	a_retire_stable: assert property (@(posedge clk) disable iff (rst)
		retire_valid && !retire_ready |=> retire_valid && $stable(retire_data))
		else $error("retire record changed under back-pressure");

endmodule

`default_nettype wire

//--- src/core_top.sv
// Pipeline core top level
`timescale 1ns/10ps
`default_nettype none

module core_top import core_pkg::*; #(
	parameter int DMEM_WORDS = 64
) (
	input  logic        clk,
	input  logic        rst,
	input  logic        inst_valid,
	output logic        inst_ready,
	input  logic [31:0] inst_data,
	output logic        retire_valid,
	input  logic        retire_ready,
	output retire_t     retire_data
);

	logic        f2d_valid, f2d_ready;
	fetch_t      f2d_data;
	logic        d2e_valid, d2e_ready;
	decode_t     d2e_data;
	logic        e2m_valid, e2m_ready;
	exec_t       e2m_data;
	logic        m2r_valid, m2r_ready;
	retire_t     m2r_data;
	logic        wb_en;
	logic [4:0]  wb_addr;
	logic [31:0] wb_data;

	inst_fetch fetch0 (.*);

	inst_decode decode0 (.*);

	alu_execute execute0 (.*);

	data_mem_stage #(
		.DMEM_WORDS(DMEM_WORDS)
	) mem0 (.*);

	retire_port retire0 (.*); // Also closes the write-back loop into decode.

endmodule

`default_nettype wire

//--- testbench/core_tb_model.svh
// Pipeline shadow model
`ifndef CORE_TB_MODEL_SVH
`define CORE_TB_MODEL_SVH

logic [31:0] regs [32];
bit          reg_ok [32];         // Cleared where a value came from an unchecked load.
logic [31:0] dmem [DMEM_WORDS];
bit          dmem_ok [DMEM_WORDS];
logic [31:0] next_pc;
retire_t     exp_q [$];           // Expected records in program order.
bit          chk_q [$];           // Set when the expected wdata is trustworthy.

function automatic logic [31:0] lcg_next(inout logic [31:0] s);
	s = s * 32'd1664525 + 32'd1013904223;
	return s;
endfunction

function automatic logic [31:0] enc_r(input logic [5:0] fn, input logic [4:0] rd, rs, rt, sh);
	return {6'h00, rs, rt, rd, sh, fn};
endfunction

function automatic logic [31:0] enc_i(input logic [5:0] op, input logic [4:0] rt, rs,
		input logic [15:0] imm);
	return {op, rs, rt, imm};
endfunction

function automatic void model_reset();
	for (int i = 0; i < 32; i++) begin
		regs[i] = '0;
		reg_ok[i] = (i == 0); // Only r0 is known before the first program runs.
	end
	for (int i = 0; i < DMEM_WORDS; i++) begin
		dmem[i] = '0;
		dmem_ok[i] = 1'b0;
	end
	next_pc = '0;
endfunction

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// One accepted instruction
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

function automatic void model_step(input logic [31:0] w);
	logic [4:0]  rs, rt, rd;
	logic [31:0] a, b, se, ze, res;
	int          idx;
	bit          ok, rt_src;
	retire_t     e;
	rs = w[25:21];
	rt = w[20:16];
	rd = w[15:11];
	a = regs[rs];
	b = regs[rt];
	se = {{16{w[15]}}, w[15:0]};
	ze = {16'h0000, w[15:0]};
	rt_src = (w[31:26] == op_rtype) || (w[31:26] == op_sw);
	ok = reg_ok[rs] && (!rt_src || reg_ok[rt]);
	idx = ((a + se) >> 2) % DMEM_WORDS; // Word index, wrapping on the memory depth.
	e.pc = next_pc;
	e.illegal = 1'b0;
	e.wen = 1'b1;
	e.waddr = rt;
	res = '0;
	case (w[31:26])
		op_rtype: begin
			e.waddr = rd;
			case (w[5:0])
				fn_addu: res = a + b;
				fn_subu: res = a - b;
				fn_and:  res = a & b;
				fn_or:   res = a | b;
				fn_xor:  res = a ^ b;
				fn_slt:  res = {31'd0, $signed(a) < $signed(b)};
				fn_sll:  res = b << w[10:6];
				fn_srl:  res = b >> w[10:6];
				default: e.illegal = 1'b1;
			endcase
		end
		op_addiu: res = a + se;
		op_slti:  res = {31'd0, $signed(a) < $signed(se)};
		op_andi:  res = a & ze;
		op_ori:   res = a | ze;
		op_xori:  res = a ^ ze;
		op_lui:   res = {w[15:0], 16'h0000};
		op_lw: begin
			res = dmem[idx];
			ok = ok && dmem_ok[idx];
		end
		op_sw: begin
			res = a + se; // A store retires with its address as wdata.
			e.wen = 1'b0;
			e.waddr = 5'd0;
			dmem[idx] = b;
			dmem_ok[idx] = ok;
		end
		default: e.illegal = 1'b1;
	endcase
	if (e.illegal) begin
		e.wen = 1'b0;
		e.waddr = 5'd0;
		res = '0;
	end
	e.wdata = res;
	if (e.wen && e.waddr != 5'd0) begin
		regs[e.waddr] = res;
		reg_ok[e.waddr] = ok;
	end
	next_pc = next_pc + 32'd4;
	exp_q.push_back(e);
	chk_q.push_back(ok);
endfunction

`endif

//--- testbench/core_tb.sv
// Pipeline core testbench
`timescale 1ns/10ps
`default_nettype none

module core_tb import core_pkg::*; ();

	localparam int DMEM_WORDS = 64;
	localparam int SEND_LIMIT = 200;  // Cycles one word may wait for inst_ready.
	localparam int DRAIN_LIMIT = 500;

	logic        clk, rst;
	logic        inst_valid, inst_ready;
	logic [31:0] inst_data;
	logic        retire_valid, retire_ready;
	retire_t     retire_data;

	logic [31:0] seed = 32'hf02f;
	logic [31:0] bp_seed = 32'hf02f; // Separate stream for back-pressure.
	logic [31:0] bp_r;
	int          mismatches, other_errors;
	bit          abort, bp_on, hold;
	retire_t     held;

	logic [5:0] alu_fns [8] = '{fn_addu, fn_subu, fn_and, fn_or, fn_xor, fn_slt, fn_sll, fn_srl};
	logic [5:0] alu_ops [6] = '{op_addiu, op_slti, op_andi, op_ori, op_xori, op_lui};
	logic [5:0] bad_ops [4] = '{6'h02, 6'h04, 6'h08, 6'h20}; // j, beq, addi, lb.
	logic [5:0] bad_fns [4] = '{6'h03, 6'h08, 6'h20, 6'h27}; // sra, jr, add, nor.

	`include "core_tb_model.svh"

	core_top #(.DMEM_WORDS(DMEM_WORDS)) dut0 (.*);

	always #2 clk = ~clk;

	// Random retire_ready while back-pressure is on. About a quarter of the cycles are low.
	always @(posedge clk) begin
		#1;
		bp_r = lcg_next(bp_seed);
		retire_ready = bp_on ? (bp_r[30] | bp_r[29]) : 1'b1;
	end

	function automatic logic [31:0] rand_alu();
		logic [31:0] r, q;
		int          sel;
		r = lcg_next(seed);
		q = lcg_next(seed);
		sel = r[16:13] % 14;
		if (sel < 8)
			return enc_r(alu_fns[sel], r[31:27], r[26:22], r[21:17], q[15:11]);
		return enc_i(alu_ops[sel - 8], r[31:27], r[26:22], q[31:16]);
	endfunction

	task automatic report_mismatch(input string name, input logic [31:0] exp, act);
		mismatches++;
		$display("mismatch at %0t: %s expected %h actual %h", $time, name, exp, act);
	endtask

	task automatic check_retire(input retire_t got);
		retire_t exp;
		bit      chk;
		if (exp_q.size() == 0) begin
			other_errors++;
			$display("error at %0t: pc %h retired with nothing outstanding", $time, got.pc);
			return;
		end
		exp = exp_q.pop_front();
		chk = chk_q.pop_front();
		a_pc: assert (got.pc == exp.pc) else report_mismatch("pc", exp.pc, got.pc);
		a_ill: assert (got.illegal == exp.illegal)
			else report_mismatch("illegal", exp.illegal, got.illegal);
		a_wen: assert (got.wen == exp.wen) else report_mismatch("wen", exp.wen, got.wen);
		a_waddr: assert (got.waddr == exp.waddr)
			else report_mismatch("waddr", exp.waddr, got.waddr);
		a_wdata: assert (!chk || got.wdata == exp.wdata)
			else report_mismatch("wdata", exp.wdata, got.wdata);
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Retire monitor
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// A handshake seen here at the falling edge completes at the next rising edge.
	always @(negedge clk) begin
		if (!rst) begin
			if (hold) begin
				a_hold: assert (retire_valid && retire_data == held) else begin
					other_errors++;
					$display("error at %0t: retire record dropped or changed while held",
						$time);
				end
			end
			hold = retire_valid && !retire_ready;
			held = retire_data;
			if (retire_valid && retire_ready)
				check_retire(retire_data);
		end
	end

	task automatic send(input logic [31:0] w);
		int waited;
		bit acc;
		if (abort)
			return;
		inst_valid = 1'b1;
		inst_data = w;
		acc = 1'b0;
		waited = 0;
		while (!acc && waited < SEND_LIMIT) begin
			@(negedge clk);
			acc = inst_ready;
			@(posedge clk);
			#1;
			waited++;
		end
		if (acc) begin
			model_step(w);
		end else begin
			other_errors++;
			abort = 1'b1;
			$display("error at %0t: word %h not accepted in %0d cycles", $time, w, SEND_LIMIT);
		end
		inst_valid = 1'b0;
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Programs
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	initial begin
		logic [31:0] r, w;
		logic [4:0]  d, n;
		int          waited;
		clk = 1'b0;
		rst = 1'b1;
		inst_valid = 1'b0;
		inst_data = '0;
		retire_ready = 1'b1;
		mismatches = 0;
		other_errors = 0;
		abort = 1'b0;
		bp_on = 1'b0;
		hold = 1'b0;
		model_reset();

		for (int i = 0; i < 8; i++) begin
			@(posedge clk);
			#1;
			a_rst: assert (!retire_valid && !inst_ready) else begin
				other_errors++;
				$display("error at %0t: retire_valid or inst_ready high in reset", $time);
			end
		end
		rst = 1'b0;
		@(negedge clk);
		a_post_rst: assert (!retire_valid && !inst_ready) else begin
			other_errors++;
			$display("error at %0t: retire_valid or inst_ready high right after reset", $time);
		end
		waited = 0;
		while (!inst_ready && waited < 20) begin
			@(negedge clk);
			waited++;
		end
		if (!inst_ready) begin
			other_errors++;
			abort = 1'b1;
			$display("error at %0t: inst_ready never rose after reset", $time);
		end
		@(posedge clk);
		#1;

		for (int k = 1; k < 32; k++) begin
			r = lcg_next(seed);
			send(enc_i(op_addiu, 5'(k), 5'd0, r[31:16]));
		end
		send(enc_i(op_addiu, 5'd0, 5'd1, 16'h0055)); // Retires with wen set while r0 stays zero.
		send(enc_r(fn_addu, 5'd2, 5'd0, 5'd0, 5'd0));
		repeat (60) send(rand_alu());

		// Each instruction consumes the previous result.
		d = 5'd1;
		for (int k = 0; k < 24; k++) begin
			r = lcg_next(seed);
			n = (r[31:27] == 5'd0) ? 5'd9 : r[31:27];
			case (r[26:25])
				2'd0: send(enc_r(fn_addu, n, d, d, 5'd0));
				2'd1: send(enc_r(fn_subu, n, r[24:20], d, 5'd0));
				2'd2: send(enc_i(op_xori, n, d, r[15:0]));
				default: send(enc_r(fn_sll, n, 5'd0, d, r[19:15]));
			endcase
			d = n;
		end

		send(enc_i(op_lw, 5'd5, 5'd0, 16'h0040)); // Word 16 has not been stored.
		send(enc_i(op_addiu, 5'd5, 5'd0, 16'h0007));
		for (int k = 0; k < 8; k++) begin
			send(enc_i(op_sw, 5'(k + 1), 5'd0, 16'(k * 4)));
			send(enc_i(op_lw, 5'(k + 10), 5'd0, 16'(k * 4 + 256 * (k % 3)))); // Aliased.
		end
		send(enc_i(op_sw, 5'd20, 5'd3, 16'hfffc));
		send(enc_i(op_lw, 5'd21, 5'd3, 16'hfffc));

		bp_on <= 1'b1;
		for (int k = 0; k < 64; k++) begin
			if (k % 8 == 7) begin
				r = lcg_next(seed);
				send(enc_i(op_sw, r[31:27], r[26:22], {r[15:2], 2'b00}));
				send(enc_i(op_lw, r[21:17], r[26:22], {r[15:2], 2'b00}));
			end else begin
				send(rand_alu());
			end
		end
		bp_on <= 1'b0;

		// Illegal words are followed by reads of the registers they name.
		for (int k = 0; k < 8; k++) begin
			r = lcg_next(seed);
			if (k % 2 == 0)
				w = {bad_ops[r[31:30]], r[25:0]};
			else
				w = {6'h00, r[25:6], bad_fns[r[31:30]]};
			send(w);
			send(enc_r(fn_or, w[20:16], w[20:16], 5'd0, 5'd0));
			send(enc_r(fn_or, w[15:11], w[15:11], 5'd0, 5'd0));
		end

		waited = 0;
		while (!abort && exp_q.size() != 0 && waited < DRAIN_LIMIT) begin
			@(posedge clk);
			waited++;
		end
		if (exp_q.size() != 0) begin
			other_errors++;
			$display("error at %0t: %0d instructions never retired", $time, exp_q.size());
		end
		repeat (8) @(posedge clk); // A stray extra record would show up here.
		$display("checks done: %0d mismatches, %0d other errors", mismatches, other_errors);
		if (mismatches == 0 && other_errors == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

endmodule

`default_nettype wire

//--- filelist.f
+incdir+testbench
src/core_pkg.sv
src/inst_fetch.sv
src/inst_decode.sv
src/alu_execute.sv
src/data_mem_stage.sv
src/retire_port.sv
src/core_top.sv
testbench/core_tb.sv

//--- Bender.yml
package:
  name: core_pipeline

sources:
  - files:
      - src/core_pkg.sv
      - src/inst_fetch.sv
      - src/inst_decode.sv
      - src/alu_execute.sv
      - src/data_mem_stage.sv
      - src/retire_port.sv
      - src/core_top.sv
  - target: test
    include_dirs:
      - testbench
    files:
      - testbench/core_tb.sv
